/* rtl/psrPkg.sv */
package psrPkg;

  localparam int psrWidth = 12; // NZCV + I + F + T + mode[4:0]
  localparam int numBanks = 5;  // svc, abt, und, irq, fiq

  // Field view of the status word, MSB first
  typedef struct packed {
    logic [3:0] flags;      // N, Z, C, V
    logic       irqDisable; // I bit
    logic       fiqDisable; // F bit
    logic       thumb;      // Carried only
    logic [4:0] mode;
  } psrFields_t;

  // Same word seen raw for storage, MSR and SRdata
  typedef union packed {
    logic [psrWidth-1:0] raw;
    psrFields_t          fields;
  } psrWord_t;

  // Bit order matches the Exceptions port
  typedef struct packed {
    logic fastInterrupt;
    logic interrupt;
    logic undefined;
    logic prefetchAbort;
    logic dataAbort;
    logic softwareInterrupt;
  } exceptions_t;

  // Processor modes
  localparam logic [4:0] modeUsr = 5'b10000;
  localparam logic [4:0] modeFiq = 5'b10001;
  localparam logic [4:0] modeIrq = 5'b10010;
  localparam logic [4:0] modeSvc = 5'b10011;
  localparam logic [4:0] modeAbt = 5'b10111;
  localparam logic [4:0] modeUnd = 5'b11011;
  localparam logic [4:0] modeSys = 5'b11111;

  // Saved status bank numbers
  typedef logic [2:0] bankIndex_t;

  localparam bankIndex_t bankSvc  = 3'd0;
  localparam bankIndex_t bankAbt  = 3'd1;
  localparam bankIndex_t bankUnd  = 3'd2;
  localparam bankIndex_t bankIrq  = 3'd3;
  localparam bankIndex_t bankFiq  = 3'd4;
  localparam bankIndex_t bankNone = 3'd7; // usr and sys have no SPSR

  // One-hot select into the fetch stage vector table
  typedef logic [6:0] vectorSel_t;

  localparam vectorSel_t vecReset     = 7'b000_0001;
  localparam vectorSel_t vecUndef     = 7'b000_0010;
  localparam vectorSel_t vecSwi       = 7'b000_0100;
  localparam vectorSel_t vecPrefetch  = 7'b000_1000;
  localparam vectorSel_t vecDataAbort = 7'b001_0000;
  localparam vectorSel_t vecIrq       = 7'b010_0000;
  localparam vectorSel_t vecFiq       = 7'b100_0000;

  // Mode to SPSR bank, unknown encodings fall to no bank
  function automatic bankIndex_t modeToBank(input logic [4:0] mode);
    case (mode)
      modeSvc: modeToBank = bankSvc;
      modeAbt: modeToBank = bankAbt;
      modeUnd: modeToBank = bankUnd;
      modeIrq: modeToBank = bankIrq;
      modeFiq: modeToBank = bankFiq;
      modeUsr,
      modeSys: modeToBank = bankNone;
      default: modeToBank = bankNone;
    endcase
  endfunction

endpackage

/* rtl/exceptionPriority.sv */
`timescale 1ns/10ps

module exceptionPriority (
  input  psrPkg::exceptions_t exceptions,
  input  psrPkg::psrWord_t    currentPsr,
  input  logic                reset,
  output logic                entryTaken,
  output logic [4:0]          entryMode,
  output psrPkg::vectorSel_t  PCVectorAddress
);

  logic [4:0] mode;
  logic       inFiq;
  logic       inIrq;
  logic       inSvc;
  logic       inAbt;
  logic       inUnd;
  psrPkg::exceptions_t allowed; // Requests left after blocking

  assign mode = currentPsr.fields.mode;

  // Already in the handler mode
  assign inFiq = (mode == psrPkg::modeFiq);
  assign inIrq = (mode == psrPkg::modeIrq);
  assign inSvc = (mode == psrPkg::modeSvc);
  assign inAbt = (mode == psrPkg::modeAbt);
  assign inUnd = (mode == psrPkg::modeUnd);

  // Mode and mask blocking
  always_comb begin
    allowed = exceptions;
    if (inAbt) begin
      allowed.dataAbort     = 1'b0; // Both aborts share abt
      allowed.prefetchAbort = 1'b0;
    end
    if (inFiq || currentPsr.fields.fiqDisable) begin
      allowed.fastInterrupt = 1'b0;
    end
    if (inIrq || currentPsr.fields.irqDisable) begin
      allowed.interrupt = 1'b0;
    end
    if (inUnd) begin
      allowed.undefined = 1'b0;
    end
    if (inSvc) begin
      allowed.softwareInterrupt = 1'b0; // SWI also lands in svc
    end
  end

  // Fixed priority, highest unblocked request wins
  always_comb begin
    entryTaken      = 1'b0;
    entryMode       = mode; // Hold mode when idle
    PCVectorAddress = '0;
    if (reset) begin
      // Reset vector while held, no bank write
      entryMode       = psrPkg::modeSvc;
      PCVectorAddress = psrPkg::vecReset;
    end else if (allowed.dataAbort) begin
      entryTaken      = 1'b1;
      entryMode       = psrPkg::modeAbt;
      PCVectorAddress = psrPkg::vecDataAbort;
    end else if (allowed.fastInterrupt) begin
      entryTaken      = 1'b1;
      entryMode       = psrPkg::modeFiq;
      PCVectorAddress = psrPkg::vecFiq;
    end else if (allowed.interrupt) begin
      entryTaken      = 1'b1;
      entryMode       = psrPkg::modeIrq;
      PCVectorAddress = psrPkg::vecIrq;
    end else if (allowed.prefetchAbort) begin
      entryTaken      = 1'b1;
      entryMode       = psrPkg::modeAbt;
      PCVectorAddress = psrPkg::vecPrefetch;
    end else if (allowed.undefined) begin
      entryTaken      = 1'b1;
      entryMode       = psrPkg::modeUnd;
      PCVectorAddress = psrPkg::vecUndef;
    end else if (allowed.softwareInterrupt) begin
      entryTaken      = 1'b1;
      entryMode       = psrPkg::modeSvc;
      PCVectorAddress = psrPkg::vecSwi;
    end
  end

endmodule

/* rtl/spsrBank.sv */
`timescale 1ns/10ps

module spsrBank (
  input  logic             clk,
  input  logic             reset,
  input  logic             write,     // Exception entry strobe
  input  logic [4:0]       writeMode, // Mode being entered
  input  psrPkg::psrWord_t writeData, // Pre-entry CPSR
  input  logic [4:0]       readMode,  // Current mode
  output psrPkg::psrWord_t savedPsr
);

  psrPkg::psrWord_t   spsr [psrPkg::numBanks];
  psrPkg::bankIndex_t writeIdx;
  psrPkg::bankIndex_t readIdx;
  logic               writeHit; // Write lands in a real bank
  logic               readHit;

  assign writeIdx = psrPkg::modeToBank(writeMode);
  assign readIdx  = psrPkg::modeToBank(readMode);

  assign writeHit = write && (writeIdx != psrPkg::bankNone);
  assign readHit  = (readIdx != psrPkg::bankNone);

  // Five banks, cleared together
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < psrPkg::numBanks; i++) begin
        spsr[i].raw <= '0;
      end
    end else if (writeHit) begin
      spsr[writeIdx] <= writeData;
    end
  end

  // usr and sys read back zero
  always_comb begin
    if (readHit) begin
      savedPsr = spsr[readIdx];
    end else begin
      savedPsr.raw = '0;
    end
  end

endmodule

/* rtl/statusReg.sv */
`timescale 1ns/10ps

module statusReg (
  input  logic             clk,
  input  logic             reset,
  input  logic             entryTaken,
  input  logic [4:0]       entryMode,
  input  psrPkg::psrWord_t savedPsr,    // SPSR of current mode
  input  logic             restoreCPSR, // Exception return
  input  logic             writeSR,     // MSR, whole word
  input  psrPkg::psrWord_t srWriteData,
  input  logic             Enable,      // ALU flag update
  input  logic [3:0]       FlagsNext,
  output psrPkg::psrWord_t currentPsr
);

  // svc, I and F set, flags and T clear
  localparam logic [psrPkg::psrWidth-1:0] resetRaw = {
    4'b0000, 1'b1, 1'b1, 1'b0, psrPkg::modeSvc
  };

  psrPkg::psrWord_t psrQ;
  psrPkg::psrWord_t psrNext;
  psrPkg::psrWord_t entryPsr; // Word after exception entry
  logic             hasBank;  // Restore only from banked modes

  assign hasBank = (psrPkg::modeToBank(psrQ.fields.mode) != psrPkg::bankNone);

  // Entry word from the field view
  always_comb begin
    entryPsr                   = psrQ; // Flags kept
    entryPsr.fields.irqDisable = 1'b1; // Every entry masks IRQ
    entryPsr.fields.fiqDisable = psrQ.fields.fiqDisable |
                                 (entryMode == psrPkg::modeFiq);
    entryPsr.fields.thumb      = 1'b0; // Handlers run in ARM state
    entryPsr.fields.mode       = entryMode;
  end

  // Entry > restore > MSR > flags
  always_comb begin
    psrNext = psrQ;
    if (entryTaken) begin
      psrNext = entryPsr;
    end else if (restoreCPSR) begin
      if (hasBank) begin
        psrNext = savedPsr;
      end
    end else if (writeSR) begin
      psrNext = srWriteData;
    end else if (Enable) begin
      psrNext.fields.flags = FlagsNext; // NZCV only
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      psrQ.raw <= resetRaw;
    end else begin
      psrQ <= psrNext;
    end
  end

  assign currentPsr = psrQ;

endmodule

/* rtl/psrUnit.sv */
`timescale 1ns/10ps

module psrUnit (
  input  logic                clk,
  input  logic                reset,
  input  psrPkg::exceptions_t Exceptions,
  input  logic [3:0]          FlagsNext,
  input  logic                Enable,
  input  logic                restoreCPSR,
  input  logic                readSR,      // MRS from SPSR when high
  input  logic                writeSR,
  input  psrPkg::psrWord_t    srWriteData,
  output psrPkg::psrWord_t    SRdata,
  output psrPkg::vectorSel_t  PCVectorAddress
);

  psrPkg::psrWord_t currentPsr;
  psrPkg::psrWord_t savedPsr;
  logic             entryTaken;
  logic [4:0]       entryMode;

  // Masking, priority, vector
  exceptionPriority priorityLogic (
    .exceptions      (Exceptions),
    .currentPsr      (currentPsr),
    .reset           (reset),
    .entryTaken      (entryTaken),
    .entryMode       (entryMode),
    .PCVectorAddress (PCVectorAddress)
  );

  // Old CPSR saved in the target mode bank
  spsrBank savedBanks (
    .clk       (clk),
    .reset     (reset),
    .write     (entryTaken),
    .writeMode (entryMode),
    .writeData (currentPsr),
    .readMode  (currentPsr.fields.mode),
    .savedPsr  (savedPsr)
  );

  statusReg cpsrReg (
    .clk         (clk),
    .reset       (reset),
    .entryTaken  (entryTaken),
    .entryMode   (entryMode),
    .savedPsr    (savedPsr),
    .restoreCPSR (restoreCPSR),
    .writeSR     (writeSR),
    .srWriteData (srWriteData),
    .Enable      (Enable),
    .FlagsNext   (FlagsNext),
    .currentPsr  (currentPsr)
  );

  assign SRdata = readSR ? savedPsr : currentPsr; // MRS source

endmodule

/* testbench/tbClock.sv */
`timescale 1ns/10ps

module tbClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  // Held for 16 rising edges, released on an edge
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* testbench/psrUnit_asserts.sv */
`timescale 1ns/10ps

module psrUnit_asserts (
  input logic                clk,
  input logic                reset,
  input psrPkg::exceptions_t Exceptions,
  input logic [3:0]          FlagsNext,
  input logic                Enable,
  input logic                restoreCPSR,
  input logic                readSR,
  input logic                writeSR,
  input psrPkg::psrWord_t    srWriteData,
  input psrPkg::psrWord_t    SRdata,
  input psrPkg::vectorSel_t  PCVectorAddress,
  input psrPkg::psrWord_t    currentPsr,  // DUT internal
  input psrPkg::psrWord_t    savedPsr     // DUT internal
);

  // svc, I and F set, flags and T clear
  localparam logic [11:0] resetWord = {4'b0000, 1'b1, 1'b1, 1'b0, psrPkg::modeSvc};

  int failures = 0; // Failed assertion count

  psrPkg::vectorSel_t expVec;
  logic [4:0]         expMode;
  logic               entryNow;
  psrPkg::psrWord_t   nextWord;    // Expected word when no entry
  logic               entryPrev;
  logic               restorePrev;
  logic               writePrev;
  logic               flagPrev;
  psrPkg::psrWord_t   oldPsr;      // Word before the last edge
  psrPkg::psrWord_t   nextPrev;
  logic [10:0]        entryExp;    // Flags, I, F, mode after entry

  // Highest unblocked request
  function automatic psrPkg::vectorSel_t ruleVector(input psrPkg::exceptions_t req,
                                                    input psrPkg::psrWord_t psr);
    logic [4:0] m;
    m = psr.fields.mode;
    ruleVector = '0;
    if (req.dataAbort && m != psrPkg::modeAbt)
      ruleVector = psrPkg::vecDataAbort;
    else if (req.fastInterrupt && m != psrPkg::modeFiq && !psr.fields.fiqDisable)
      ruleVector = psrPkg::vecFiq;
    else if (req.interrupt && m != psrPkg::modeIrq && !psr.fields.irqDisable)
      ruleVector = psrPkg::vecIrq;
    else if (req.prefetchAbort && m != psrPkg::modeAbt)
      ruleVector = psrPkg::vecPrefetch;
    else if (req.undefined && m != psrPkg::modeUnd)
      ruleVector = psrPkg::vecUndef;
    else if (req.softwareInterrupt && m != psrPkg::modeSvc)
      ruleVector = psrPkg::vecSwi;
  endfunction

  function automatic logic [4:0] handlerMode(input psrPkg::vectorSel_t vec);
    case (vec)
      psrPkg::vecDataAbort,
      psrPkg::vecPrefetch: handlerMode = psrPkg::modeAbt;
      psrPkg::vecFiq:      handlerMode = psrPkg::modeFiq;
      psrPkg::vecIrq:      handlerMode = psrPkg::modeIrq;
      psrPkg::vecUndef:    handlerMode = psrPkg::modeUnd;
      default:             handlerMode = psrPkg::modeSvc; // SWI
    endcase
  endfunction

  function automatic logic banked(input logic [4:0] mode);
    banked = mode inside {psrPkg::modeFiq, psrPkg::modeIrq, psrPkg::modeSvc,
                          psrPkg::modeAbt, psrPkg::modeUnd};
  endfunction

  // Thumb left out of entry checks
  function automatic logic [10:0] coreBits(input psrPkg::psrWord_t psr);
    coreBits = {psr.fields.flags, psr.fields.irqDisable, psr.fields.fiqDisable,
                psr.fields.mode};
  endfunction

  assign expVec   = ruleVector(Exceptions, currentPsr);
  assign expMode  = handlerMode(expVec);
  assign entryNow = (expVec != '0);

  // Restore, then MSR, then flags
  always_comb begin
    nextWord = currentPsr;
    if (restoreCPSR) begin
      if (banked(currentPsr.fields.mode)) begin
        nextWord = savedPsr; // usr and sys keep the word
      end
    end else if (writeSR) begin
      nextWord = srWriteData;
    end else if (Enable) begin
      nextWord.fields.flags = FlagsNext;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      entryPrev   <= 1'b0;
      restorePrev <= 1'b0;
      writePrev   <= 1'b0;
      flagPrev    <= 1'b0;
      oldPsr      <= '0;
      nextPrev    <= resetWord; // Word seen right after release
      entryExp    <= '0;
    end else begin
      entryPrev   <= entryNow;
      restorePrev <= restoreCPSR && !entryNow; // Entry wins over all
      writePrev   <= writeSR && !restoreCPSR && !entryNow;
      flagPrev    <= Enable && !writeSR && !restoreCPSR && !entryNow;
      oldPsr      <= currentPsr;
      nextPrev    <= nextWord;
      entryExp    <= {currentPsr.fields.flags, 1'b1,
                      currentPsr.fields.fiqDisable | (expMode == psrPkg::modeFiq), expMode};
    end
  end

  resetVector: assert property (@(posedge clk) reset |-> PCVectorAddress == psrPkg::vecReset)
    else begin
      failures++;
      $error("FAILED t=%0t PCVectorAddress got %b expected %b", $time,
             $sampled(PCVectorAddress), psrPkg::vecReset);
    end

  resetState: assert property (@(posedge clk) $fell(reset) && !readSR |-> SRdata.raw == resetWord)
    else begin
      failures++;
      $error("FAILED t=%0t SRdata got %h expected %h", $time, $sampled(SRdata.raw), resetWord);
    end

  vectorPick: assert property (@(posedge clk) disable iff (reset) PCVectorAddress == expVec)
    else begin
      failures++;
      $error("FAILED t=%0t PCVectorAddress got %b expected %b", $time,
             $sampled(PCVectorAddress), $sampled(expVec));
    end

  entryState: assert property (@(posedge clk) disable iff (reset)
                               entryPrev |-> coreBits(currentPsr) == entryExp)
    else begin
      failures++;
      $error("FAILED t=%0t currentPsr got %h expected %h", $time,
             coreBits($sampled(currentPsr)), $sampled(entryExp));
    end

  // MRS of the SPSR just after entry
  entrySaved: assert property (@(posedge clk) disable iff (reset)
                               entryPrev && readSR |-> SRdata.raw == oldPsr.raw)
    else begin
      failures++;
      $error("FAILED t=%0t SRdata got %h expected %h", $time,
             $sampled(SRdata.raw), $sampled(oldPsr.raw));
    end

  restoreWord: assert property (@(posedge clk) disable iff (reset)
                                restorePrev |-> currentPsr.raw == nextPrev.raw)
    else begin
      failures++;
      $error("FAILED t=%0t currentPsr after restore got %h expected %h", $time,
             $sampled(currentPsr.raw), $sampled(nextPrev.raw));
    end

  msrWrite: assert property (@(posedge clk) disable iff (reset)
                             writePrev |-> currentPsr.raw == nextPrev.raw)
    else begin
      failures++;
      $error("FAILED t=%0t currentPsr after MSR got %h expected %h", $time,
             $sampled(currentPsr.raw), $sampled(nextPrev.raw));
    end

  flagUpdate: assert property (@(posedge clk) disable iff (reset)
                               flagPrev |-> currentPsr.raw == nextPrev.raw)
    else begin
      failures++;
      $error("FAILED t=%0t currentPsr after flag update got %h expected %h", $time,
             $sampled(currentPsr.raw), $sampled(nextPrev.raw));
    end

  // MRS of the CPSR after any cycle without entry
  srDataCurrent: assert property (@(posedge clk) disable iff (reset)
                                  !entryPrev && !readSR |-> SRdata.raw == nextPrev.raw)
    else begin
      failures++;
      $error("FAILED t=%0t SRdata got %h expected %h", $time, $sampled(SRdata.raw),
             $sampled(nextPrev.raw));
    end

endmodule

/* testbench/psrUnit_tb.sv */
`timescale 1ns/10ps

module psrUnit_tb;

  logic                clk;
  logic                reset;
  psrPkg::exceptions_t Exceptions;
  logic [3:0]          FlagsNext;
  logic                Enable;
  logic                restoreCPSR;
  logic                readSR;
  logic                writeSR;
  psrPkg::psrWord_t    srWriteData;
  psrPkg::psrWord_t    SRdata;
  psrPkg::vectorSel_t  PCVectorAddress;

  integer      seed = 32'h23c0d541;
  logic [31:0] rnd;
  int          timeouts = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          errorsBefore = 0; // Errors counted before the current test

  tbClock clockGen (
    .clk   (clk),
    .reset (reset)
  );

  psrUnit UUT (
    .clk             (clk),
    .reset           (reset),
    .Exceptions      (Exceptions),
    .FlagsNext       (FlagsNext),
    .Enable          (Enable),
    .restoreCPSR     (restoreCPSR),
    .readSR          (readSR),
    .writeSR         (writeSR),
    .srWriteData     (srWriteData),
    .SRdata          (SRdata),
    .PCVectorAddress (PCVectorAddress)
  );

  bind psrUnit psrUnit_asserts checks (
    .clk (clk), .reset (reset), .Exceptions (Exceptions), .FlagsNext (FlagsNext),
    .Enable (Enable), .restoreCPSR (restoreCPSR), .readSR (readSR), .writeSR (writeSR),
    .srWriteData (srWriteData), .SRdata (SRdata), .PCVectorAddress (PCVectorAddress),
    .currentPsr (currentPsr), .savedPsr (savedPsr)
  );

  function automatic logic [4:0] modeByIndex(input logic [2:0] idx);
    case (idx)
      3'd0:    modeByIndex = psrPkg::modeFiq;
      3'd1:    modeByIndex = psrPkg::modeIrq;
      3'd2:    modeByIndex = psrPkg::modeSvc;
      3'd3:    modeByIndex = psrPkg::modeAbt;
      3'd4:    modeByIndex = psrPkg::modeUnd;
      3'd5:    modeByIndex = psrPkg::modeSys;
      default: modeByIndex = psrPkg::modeUsr;
    endcase
  endfunction

  task automatic clearInputs();
    Exceptions  <= '0;
    FlagsNext   <= 4'h0;
    Enable      <= 1'b0;
    restoreCPSR <= 1'b0;
    readSR      <= 1'b0;
    writeSR     <= 1'b0;
    srWriteData <= '0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      clearInputs();
    end
  endtask

  // MSR of a whole word, thumb clear
  task automatic writeWord(input logic [3:0] flags, input logic irqOff, input logic fiqOff,
                           input logic [4:0] mode);
    @(posedge clk);
    clearInputs();
    writeSR         <= 1'b1;
    srWriteData.raw <= {flags, irqOff, fiqOff, 1'b0, mode};
  endtask

  task automatic raiseRequests(input psrPkg::exceptions_t req);
    @(posedge clk);
    clearInputs();
    Exceptions <= req;
  endtask

  task automatic readSaved();
    @(posedge clk);
    clearInputs();
    readSR <= 1'b1; // MRS from SPSR
  endtask

  task automatic setFlags(input logic [3:0] flags);
    @(posedge clk);
    clearInputs();
    Enable    <= 1'b1;
    FlagsNext <= flags;
  endtask

  task automatic returnFromHandler();
    @(posedge clk);
    clearInputs();
    restoreCPSR <= 1'b1;
  endtask

  task automatic waitResetDone(input int limit);
    int count;
    count = 0;
    @(posedge clk);
    while (reset && count < limit) begin
      @(negedge clk);
      count++;
    end
    if (reset) begin
      timeouts++;
      $display("Timeout at %0t: reset still asserted after %0d cycles", $time, limit);
    end
  endtask

  // Polls the current word until the mode shows up
  task automatic waitMode(input logic [4:0] mode, input int limit);
    int count;
    count = 0;
    @(posedge clk);
    clearInputs();
    @(negedge clk);
    while (SRdata.fields.mode != mode && count < limit) begin
      @(negedge clk);
      count++;
    end
    if (SRdata.fields.mode != mode) begin
      timeouts++;
      $display("Timeout at %0t: mode %b never showed up on SRdata", $time, mode);
    end
  endtask

  task automatic endTest(input string name);
    int errors;
    idle(2); // Let late assertions fire
    errors = UUT.checks.failures + timeouts - errorsBefore;
    testsRun++;
    if (errors == 0) begin
      $display("test %-8s passed", name);
    end else begin
      testsFailed++;
      $display("test %-8s failed with %0d errors", name, errors);
    end
    errorsBefore = UUT.checks.failures + timeouts;
  endtask

  initial begin
    clearInputs();
    waitResetDone(40);
    endTest("reset");

    // Random masks and modes, then a random request set
    for (int i = 0; i < 48; i++) begin
      rnd = $random(seed);
      writeWord(rnd[3:0], rnd[4], rnd[5], modeByIndex(rnd[8:6]));
      raiseRequests(rnd[14:9]);
      readSaved();
    end
    endTest("priority");

    writeWord(4'b1010, 1'b0, 1'b0, psrPkg::modeUsr);
    raiseRequests(6'b100000);            // FIQ
    waitMode(psrPkg::modeFiq, 8);
    readSaved();
    writeWord(4'b0101, 1'b0, 1'b1, psrPkg::modeUsr);
    raiseRequests(6'b100000);            // Masked by F
    writeWord(4'b0011, 1'b1, 1'b0, psrPkg::modeUsr);
    raiseRequests(6'b010000);            // Masked by I
    raiseRequests(6'b111111);            // Data abort wins
    waitMode(psrPkg::modeAbt, 8);
    endTest("entry");

    writeWord(4'b1100, 1'b0, 1'b0, psrPkg::modeUsr);
    raiseRequests(6'b001000);            // Undefined
    waitMode(psrPkg::modeUnd, 8);
    setFlags(4'b0001);
    returnFromHandler();
    waitMode(psrPkg::modeUsr, 8);
    returnFromHandler();                 // No bank in usr
    writeWord(4'b0110, 1'b1, 1'b1, psrPkg::modeSys);
    returnFromHandler();
    endTest("restore");

    // Mixed strobes, entry sometimes on top
    for (int i = 0; i < 64; i++) begin
      rnd = $random(seed);
      @(posedge clk);
      clearInputs();
      Enable          <= rnd[0];
      FlagsNext       <= rnd[4:1];
      writeSR         <= rnd[5];
      srWriteData.raw <= {rnd[9:6], rnd[10], rnd[11], 1'b0, modeByIndex(rnd[14:12])};
      restoreCPSR     <= (rnd[17:15] == 3'd0);
      Exceptions      <= (rnd[19:18] == 2'd0) ? rnd[25:20] : 6'd0;
      readSR          <= rnd[26];
    end
    endTest("update");

    $display("tests run %0d, failed %0d, assertion failures %0d, timeouts %0d",
             testsRun, testsFailed, UUT.checks.failures, timeouts);
    if (testsFailed == 0 && UUT.checks.failures == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/psrPkg.sv
rtl/exceptionPriority.sv
rtl/spsrBank.sv
rtl/statusReg.sv
rtl/psrUnit.sv
testbench/tbClock.sv
testbench/psrUnit_asserts.sv
testbench/psrUnit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= psrUnit_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
